// File: flist.f
hw/prefetch_pkg.sv
hw/fetch_fsm.sv
hw/fetch_pc.sv
hw/line_buffer.sv
hw/instr_aligner.sv
hw/prefetch_top.sv
testbench/wb_line_mem.sv
testbench/tb_prefetch.sv

// File: run.sh
#!/bin/sh
# compile the prefetch buffer with its testbench and run the simulation
# the exit status is nonzero when the build fails or a check stops the run

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_prefetch \
    -f flist.f \
    -o sim_prefetch &&
  ./obj_dir/sim_prefetch || exit 1

// File: testbench/tb_prefetch.sv
module tb_prefetch import prefetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          mem_words = 256;
  localparam int          num_rows  = 8;
  localparam int unsigned timeout   = 200;
  localparam logic [31:0] seed      = 32'h1c58_502b;

  // branch target, instructions to accept, ready low percentage, branch into a fetch
  typedef struct packed {
    addr_t       target;
    logic [31:0] count;
    logic [31:0] low_pct;
    logic        busy_branch;
  } row_t;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   branch;
  addr_t  branch_addr;
  logic   ready;
  logic   valid;
  instr_t rdata;
  addr_t  addr;
  logic   busy;
  logic   wb_cyc;
  logic   wb_stb;
  addr_t  wb_adr;
  logic   wb_ack;
  line_t  wb_dat;

  row_t        rows [num_rows];
  logic [31:0] mem_copy [mem_words];
  logic        prev_cyc = 1'b0;
  logic        prev_ack = 1'b0;
  addr_t       prev_adr = '0;

  always #5 clk = ~clk;

  prefetch_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .ready_i       (ready),
    .valid_o       (valid),
    .rdata_o       (rdata),
    .addr_o        (addr),
    .busy_o        (busy),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_adr_o      (wb_adr),
    .wb_ack_i      (wb_ack),
    .wb_dat_i      (wb_dat)
  );

  wb_line_mem u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    stop_run($sformatf("error %s expected %h got %h", name, exp_val, act_val));
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [15:0] half_at(input addr_t a);
    logic [31:0] word;
    word = mem_copy[a[9:2]];
    return a[1] ? word[31:16] : word[15:0];
  endfunction

  // low two bits both set mark a 32-bit instruction
  function automatic instr_t expected_instr(input addr_t a);
    logic [15:0] lo;
    lo = half_at(a);
    if (lo[1:0] != 2'b11) begin
      return {16'h0, lo};
    end
    return {half_at(a + 32'd2), lo};
  endfunction

  task automatic check_quiet();
    assert (!valid && !wb_cyc && !wb_stb && !busy)
      else stop_run("valid_o, busy_o or the bus was active before the first branch");
  endtask

  // called on a falling edge, the pulse covers the next rising edge
  task automatic pulse_branch(input addr_t target);
    branch      = 1'b1;
    branch_addr = target;
    ready       = 1'b1;
    #1;
    assert (!valid) else report_mismatch("valid_o", 32'h0, {31'h0, valid});
  endtask

  task automatic branch_in_cycle(input addr_t target);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    branch = 1'b0;
    while (!wb_cyc) begin
      waited++;
      if (waited > timeout) begin
        stop_run("timeout waiting for a line fetch to branch into");
      end
      @(negedge clk);
    end
    pulse_branch(target);
  endtask

  task automatic run_stream(input addr_t start, input logic [31:0] count,
                            input logic [31:0] low_pct);
    addr_t       exp_pc;
    instr_t      exp_instr;
    logic        held;
    int unsigned taken;
    int unsigned waited;
    exp_pc = start;
    held   = 1'b0;
    taken  = 0;
    waited = 0;
    while (taken < count) begin
      @(negedge clk);
      branch = 1'b0;
      ready  = ($urandom_range(99, 0) >= low_pct);
      #1;
      // a held instruction keeps the predicted pc, so the value checks below cover it
      if (held) begin
        assert (valid) else stop_run("valid_o dropped before its instruction was taken");
      end
      if (valid) begin
        exp_instr = expected_instr(exp_pc);
        assert (addr == exp_pc) else report_mismatch("addr_o", exp_pc, addr);
        assert (rdata == exp_instr) else report_mismatch("rdata_o", exp_instr, rdata);
        if (ready) begin
          exp_pc = exp_pc + ((exp_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
          taken++;
          waited = 0;
        end
      end
      held = valid & ~ready;
      waited++;
      if (waited > timeout) begin
        stop_run("timeout waiting for an instruction on valid_o");
      end
    end
  endtask

  ////////////////////
  // bus monitor
  ////////////////////

  always @(negedge clk) begin
    assert (wb_stb == wb_cyc) else report_mismatch("wb_stb_o", {31'h0, wb_cyc}, {31'h0, wb_stb});
    if (wb_cyc) begin
      assert (wb_adr[3:0] == 4'h0) else stop_run("wb_adr_o is not aligned to a 16-byte line");
    end
    if (prev_cyc && !prev_ack) begin
      assert (wb_cyc) else stop_run("wb_cyc_o fell before the acknowledge");
      assert (wb_adr == prev_adr) else report_mismatch("wb_adr_o", prev_adr, wb_adr);
    end
    if (prev_cyc && prev_ack) begin
      assert (!wb_cyc) else stop_run("wb_cyc_o stayed high after the acknowledge");
    end
    prev_cyc = wb_cyc;
    prev_ack = wb_ack;
    prev_adr = wb_adr;
  end

  initial begin
    void'($urandom(seed));
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;

    // offset 14 targets start on a possible crossword
    rows[0] = '{32'h0000_0000, 32'd24, 32'd0,  1'b0};
    rows[1] = '{32'h0000_000e, 32'd20, 32'd30, 1'b0};
    rows[2] = '{32'h0000_0111, 32'd30, 32'd50, 1'b1};
    rows[3] = '{32'h0000_01fe, 32'd20, 32'd0,  1'b1};
    rows[4] = '{32'h0000_03fe, 32'd24, 32'd20, 1'b0};
    rows[5] = '{32'h0000_02ae, 32'd30, 32'd60, 1'b0};
    rows[6] = '{32'h0000_013c, 32'd20, 32'd10, 1'b1};
    rows[7] = '{32'h0000_008e, 32'd40, 32'd40, 1'b0};

    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_quiet();
    end
    for (int i = 0; i < mem_words; i++) begin
      mem_copy[i] = u_mem.mem[i];
    end
    rst_n = 1'b1;
    ready = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      #1;
      check_quiet();
    end

    // each row branches from wherever the previous stream stopped
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clk);
      if (rows[i].busy_branch) begin
        pulse_branch(rows[i].target ^ 32'h0000_0240);
        branch_in_cycle(rows[i].target);
      end else begin
        pulse_branch(rows[i].target);
      end
      run_stream({rows[i].target[31:1], 1'b0}, rows[i].count, rows[i].low_pct);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: testbench/wb_line_mem.sv
module wb_line_mem import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  addr_t wb_adr_i,
  output logic  wb_ack_o,
  output line_t wb_dat_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words = 256;

  logic [31:0] mem [mem_words];
  logic [1:0]  wait_cnt;
  logic [7:0]  word_idx;

  // each halfword is a compressed or an uncompressed parcel at random
  function automatic logic [15:0] random_half();
    logic [15:0] half;
    half = 16'($urandom);
    if ($urandom_range(1, 0) == 1) begin
      half[1:0] = 2'b11;
    end else if (half[1:0] == 2'b11) begin
      half[0] = 1'b0;
    end
    return half;
  endfunction

  // filled just after the generator is seeded at time zero
  initial begin
    #1;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {random_half(), random_half()};
    end
  end

  ////////////////////
  // line read
  ////////////////////

  // word index wraps on the memory size
  assign word_idx = wb_adr_i[9:2];

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      wb_dat_o[k*32 +: 32] = mem[word_idx + 8'(k)];
    end
  end

  // 0 to 3 wait cycles, drawn anew after each acknowledge
  assign wb_ack_o = wb_cyc_i & wb_stb_i & (wait_cnt == 2'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= 2'd0;
    end else if (wb_ack_o) begin
      wait_cnt <= 2'($urandom_range(3, 0));
    end else if (wb_cyc_i && wb_stb_i) begin
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

endmodule

// File: hw/prefetch_top.sv
module prefetch_top import prefetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,

  // core side
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,
  output logic   busy_o,

  // wishbone classic master, read only
  output logic   wb_cyc_o,
  output logic   wb_stb_o,
  output addr_t  wb_adr_o,
  input  logic   wb_ack_i,
  input  line_t  wb_dat_i
);

  logic  fetch_req;
  logic  fetch_next_line;
  logic  line_done;
  line_t line_data;
  addr_t pc;
  logic  is_compressed;
  logic  is_crossword;
  logic  ends_line;
  logic  save_half;
  logic  use_saved_half;
  logic  advance;
  logic  fsm_busy;

  fetch_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_i          (branch_i),
    .ready_i           (ready_i),
    .line_done_i       (line_done),
    .is_crossword_i    (is_crossword),
    .ends_line_i       (ends_line),
    .fetch_req_o       (fetch_req),
    .fetch_next_line_o (fetch_next_line),
    .save_half_o       (save_half),
    .use_saved_half_o  (use_saved_half),
    .advance_o         (advance),
    .valid_o           (valid_o),
    .busy_o            (fsm_busy)
  );

  fetch_pc u_pc (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .advance_i       (advance),
    .is_compressed_i (is_compressed),
    .pc_o            (pc)
  );

  line_buffer u_line (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_i       (fetch_req),
    .fetch_next_line_i (fetch_next_line),
    .pc_i              (pc),
    .line_done_o       (line_done),
    .line_o            (line_data),
    .wb_cyc_o          (wb_cyc_o),
    .wb_stb_o          (wb_stb_o),
    .wb_adr_o          (wb_adr_o),
    .wb_ack_i          (wb_ack_i),
    .wb_dat_i          (wb_dat_i)
  );

  instr_aligner u_align (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_i             (pc),
    .line_i           (line_data),
    .save_half_i      (save_half),
    .use_saved_half_i (use_saved_half),
    .rdata_o          (rdata_o),
    .is_compressed_o  (is_compressed),
    .is_crossword_o   (is_crossword),
    .ends_line_o      (ends_line)
  );

  assign addr_o = pc;
  // busy while a line is pending or the bus cycle is still open
  assign busy_o = wb_cyc_o | fsm_busy;

endmodule

// File: hw/instr_aligner.sv
module instr_aligner import prefetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  addr_t  pc_i,
  input  line_t  line_i,
  input  logic   save_half_i,
  input  logic   use_saved_half_i,
  output instr_t rdata_o,
  output logic   is_compressed_o,
  output logic   is_crossword_o,
  output logic   ends_line_o
);

  logic [line_off_w-2:0] lo_idx;
  logic [line_off_w-2:0] hi_idx;
  logic [half_w-1:0]     lo_half;
  logic [half_w-1:0]     hi_half;
  logic [half_w-1:0]     low_half;
  logic [half_w-1:0]     saved_q;
  logic                  is_compressed;
  logic [line_off_w:0]   step_end;

  ////////////////////
  // halfword select
  ////////////////////

  assign lo_idx = pc_i[line_off_w-1:1];
  // wraps to the first halfword, which is where a crossword continues
  assign hi_idx = lo_idx + 1'b1;

  assign lo_half  = line_i[lo_idx*half_w +: half_w];
  assign hi_half  = line_i[hi_idx*half_w +: half_w];
  assign low_half = use_saved_half_i ? saved_q : lo_half;

  assign is_compressed = (low_half[1:0] != 2'b11);

  assign rdata_o = is_compressed ? {{(instr_w-half_w){1'b0}}, low_half} : {hi_half, low_half};

  ////////////////////
  // line position
  ////////////////////

  assign step_end = {1'b0, pc_i[line_off_w-1:0]}
                  + (is_compressed ? (line_off_w+1)'(2) : (line_off_w+1)'(4));

  assign is_crossword_o  = ~is_compressed & (pc_i[line_off_w-1:0] == line_off_w'(last_half_off));
  assign ends_line_o     = step_end[line_off_w];
  assign is_compressed_o = is_compressed;

  // lower half of a crossword, kept while the next line is fetched
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      saved_q <= '0;
    end else if (save_half_i) begin
      saved_q <= lo_half;
    end
  end

endmodule

// File: hw/line_buffer.sv
module line_buffer import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  fetch_req_i,
  input  logic  fetch_next_line_i,
  input  addr_t pc_i,
  output logic  line_done_o,
  output line_t line_o,

  // wishbone classic master
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output addr_t wb_adr_o,
  input  logic  wb_ack_i,
  input  line_t wb_dat_i
);

  logic  cyc_q;
  addr_t adr_q;
  addr_t line_base;
  addr_t req_adr;
  line_t line_q;
  logic  line_done;

  ////////////////////
  // request address
  ////////////////////

  assign line_base = {pc_i[addr_w-1:line_off_w], {line_off_w{1'b0}}};

  // crossword fetches need the line after the one holding pc
  assign req_adr = fetch_next_line_i ? line_base + addr_t'(line_bytes) : line_base;

  ////////////////////
  // bus cycle
  ////////////////////

  assign line_done = cyc_q & wb_ack_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
      adr_q <= '0;
    end else if (line_done) begin
      cyc_q <= 1'b0;
    end else if (!cyc_q && fetch_req_i) begin
      cyc_q <= 1'b1;
      adr_q <= req_adr;
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if (line_done) begin
      line_q <= wb_dat_i;
    end
  end

  assign wb_cyc_o    = cyc_q;
  assign wb_stb_o    = cyc_q;
  assign wb_adr_o    = adr_q;
  assign line_done_o = line_done;
  assign line_o      = line_q;

endmodule

// File: hw/fetch_pc.sv
module fetch_pc import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  advance_i,
  input  logic  is_compressed_i,
  output addr_t pc_o
);

  addr_t pc_q;
  addr_t pc_d;
  addr_t step;

  ////////////////////
  // step and load
  ////////////////////

  // compressed instructions are one halfword long
  assign step = is_compressed_i ? addr_t'(2) : addr_t'(4);

  always_comb begin
    pc_d = pc_q;
    if (branch_i) begin
      // instructions are halfword aligned
      pc_d = {branch_addr_i[addr_w-1:1], 1'b0};
    end else if (advance_i) begin
      pc_d = pc_q + step;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: hw/fetch_fsm.sv
module fetch_fsm import prefetch_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic branch_i,
  input  logic ready_i,
  input  logic line_done_i,
  input  logic is_crossword_i,
  input  logic ends_line_i,
  output logic fetch_req_o,
  output logic fetch_next_line_o,
  output logic save_half_o,
  output logic use_saved_half_o,
  output logic advance_o,
  output logic valid_o,
  output logic busy_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic         valid;
  logic         outstanding;

  ////////////////////
  // outputs
  ////////////////////

  // a crossword in VALID is not complete yet, so it is not presented
  assign valid = ((state_q == VALID) & ~is_crossword_i) | (state_q == CROSS_VALID);

  assign valid_o   = valid & ~branch_i;
  assign advance_o = valid_o & ready_i;

  assign fetch_req_o       = (state_q == FETCH) | (state_q == CROSS_FETCH);
  assign fetch_next_line_o = (state_q == CROSS_FETCH);
  assign save_half_o       = (state_q == VALID) & is_crossword_i & ~branch_i;
  assign use_saved_half_o  = (state_q == CROSS_VALID);

  // a bus cycle is open or starts at this edge in these states
  assign outstanding = (state_q == FETCH) | (state_q == CROSS_FETCH) | (state_q == DRAIN);
  assign busy_o      = outstanding;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        state_d = IDLE;
      end
      FETCH: begin
        if (line_done_i) begin
          state_d = VALID;
        end
      end
      DRAIN: begin
        // stale line is dropped, refetch at the new pc
        if (line_done_i) begin
          state_d = FETCH;
        end
      end
      VALID: begin
        if (is_crossword_i) begin
          state_d = CROSS_FETCH;
        end else if (advance_o && ends_line_i) begin
          state_d = FETCH;
        end
      end
      CROSS_FETCH: begin
        if (line_done_i) begin
          state_d = CROSS_VALID;
        end
      end
      CROSS_VALID: begin
        // pc steps into the new line, which is already held
        if (advance_o) begin
          state_d = VALID;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // branch overrides everything
    if (branch_i) begin
      if (outstanding && !line_done_i) begin
        state_d = DRAIN;
      end else begin
        state_d = FETCH;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hw/prefetch_pkg.sv
package prefetch_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned addr_w  = 32;
  localparam int unsigned instr_w = 32;
  localparam int unsigned line_w  = 128;
  localparam int unsigned half_w  = 16;

  ////////////////////
  // line geometry
  ////////////////////

  localparam int unsigned line_bytes    = 16;
  localparam int unsigned line_off_w    = 4;
  // byte offset of the last halfword in a line
  localparam int unsigned last_half_off = 14;

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [instr_w-1:0] instr_t;
  typedef logic [line_w-1:0]  line_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    VALID,
    CROSS_FETCH,
    CROSS_VALID
  } fetch_state_t;

endpackage
